// ==== ddr2_cache_pkg.sv ====
`default_nettype none

package ddr2_cache_pkg;

   // Cache geometry
   localparam int LINE_IDX_W = 2;
   localparam logic [LINE_IDX_W:0] NUM_LINES = 1 << LINE_IDX_W;
   localparam int WORDS_PER_LINE_LOG2 = 5;
   // Each memory command moves two 128-bit beats, 32 bytes
   localparam int BEATS_PER_CMD = 2;
   // Byte address bits above the line offset
   localparam int TAG_W = 32 - WORDS_PER_LINE_LOG2 - 2;

   typedef logic [31:0] wb_addr_t;
   typedef logic [31:0] wb_data_t;
   typedef logic [127:0] mem_data_t;
   typedef logic [TAG_W-1:0] tag_t;

   typedef enum logic {MEM_WRITE = 1'b0, MEM_READ = 1'b1} mem_cmd_e;

   typedef enum logic [1:0] {ST_IDLE, ST_WRITEBACK, ST_FILL} miss_state_e;

   typedef enum logic [2:0] {
      CTI_CLASSIC = 3'b000,
      CTI_INCR    = 3'b010,
      CTI_END     = 3'b111
   } wb_cti_e;

   typedef enum logic [1:0] {BTE_LINEAR, BTE_WRAP4, BTE_WRAP8, BTE_WRAP16} wb_bte_e;

endpackage

`default_nettype wire

// ==== cache_tag_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_tag_reg (
   input  wire                       wb_clk,
   input  wire                       wb_rst,
   input  wire ddr2_cache_pkg::tag_t tag_i,
   input  wire                       validate_i,
   input  wire                       invalidate_i,
   input  wire                       set_dirty_i,
   output logic                      hit_o,
   output logic                      valid_o,
   output logic                      dirty_o,
   output ddr2_cache_pkg::tag_t      tag_o
);

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         valid_o <= 1'b0;
         dirty_o <= 1'b0;
      end else if (validate_i) begin
         valid_o <= 1'b1;
         dirty_o <= 1'b0;
      end else if (invalidate_i) begin
         valid_o <= 1'b0;
         dirty_o <= 1'b0;
      end else if (set_dirty_i && valid_o) begin
         dirty_o <= 1'b1;
      end
   end

   // Tag is captured when the line is filled
   always_ff @(posedge wb_clk) begin
      if (validate_i) begin
         tag_o <= tag_i;
      end
   end

   assign hit_o = valid_o && (tag_o == tag_i);

   a_no_val_inval: assert property (@(posedge wb_clk) disable iff (wb_rst)
      !(validate_i && invalidate_i))
      else $error("line validated and invalidated together");

endmodule

`default_nettype wire

// ==== cache_line_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_line_ctrl #(
   parameter int num_lines = ddr2_cache_pkg::NUM_LINES
) (
   input  wire                         wb_clk,
   input  wire                         wb_rst,
   input  wire                         req_i,
   input  wire                         cache_write_i,
   input  wire [num_lines-1:0]         line_hit_i,
   input  wire [num_lines-1:0]         line_valid_i,
   input  wire [num_lines-1:0]         line_dirty_i,
   input  wire ddr2_cache_pkg::tag_t   line_tag_i [num_lines],
   input  wire                         wb_done_i,
   input  wire                         fill_done_i,
   output logic [num_lines-1:0]        validate_o,
   output logic [num_lines-1:0]        invalidate_o,
   output logic [num_lines-1:0]        set_dirty_o,
   output logic [$clog2(num_lines)-1:0] sel_line_o,
   output ddr2_cache_pkg::tag_t        victim_tag_o,
   output logic                        start_wb_o,
   output logic                        start_fill_o
);

   localparam int line_w = $clog2(num_lines);

   ddr2_cache_pkg::miss_state_e state_q;
   logic [line_w-1:0] rr_q;
   logic [line_w-1:0] sel_q;
   logic [line_w-1:0] hit_enc;
   logic any_hit;
   logic miss;
   logic victim_dirty;

   assign any_hit = |line_hit_i;
   assign miss = (state_q == ddr2_cache_pkg::ST_IDLE) && req_i && !any_hit;
   assign victim_dirty = line_valid_i[rr_q] && line_dirty_i[rr_q];

   always_comb begin
      hit_enc = '0;
      for (int i = 0; i < num_lines; i++) begin
         if (line_hit_i[i]) begin
            hit_enc = line_w'(i);
         end
      end
   end

   // A hitting line is used directly, otherwise the line under transfer
   assign sel_line_o = (state_q == ddr2_cache_pkg::ST_IDLE && any_hit) ? hit_enc : sel_q;
   assign victim_tag_o = line_tag_i[sel_q];

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         state_q <= ddr2_cache_pkg::ST_IDLE;
         rr_q <= '0;
         sel_q <= '0;
         start_wb_o <= 1'b0;
         start_fill_o <= 1'b0;
      end else begin
         start_wb_o <= 1'b0;
         start_fill_o <= 1'b0;
         case (state_q)
            ddr2_cache_pkg::ST_IDLE: begin
               if (miss) begin
                  sel_q <= rr_q;
                  rr_q <= (rr_q == line_w'(num_lines - 1)) ? '0 : rr_q + 1'b1;
                  if (victim_dirty) begin
                     start_wb_o <= 1'b1;
                     state_q <= ddr2_cache_pkg::ST_WRITEBACK;
                  end else begin
                     start_fill_o <= 1'b1;
                     state_q <= ddr2_cache_pkg::ST_FILL;
                  end
               end
            end
            ddr2_cache_pkg::ST_WRITEBACK: begin
               if (wb_done_i) begin
                  start_fill_o <= 1'b1;
                  state_q <= ddr2_cache_pkg::ST_FILL;
               end
            end
            ddr2_cache_pkg::ST_FILL: begin
               if (fill_done_i) begin
                  state_q <= ddr2_cache_pkg::ST_IDLE;
               end
            end
            default: state_q <= ddr2_cache_pkg::ST_IDLE;
         endcase
      end
   end

   // Tag updates land on the same edge as the state change
   always_comb begin
      validate_o = '0;
      invalidate_o = '0;
      set_dirty_o = '0;
      if (miss && !victim_dirty) begin
         invalidate_o[rr_q] = 1'b1;
      end
      if (state_q == ddr2_cache_pkg::ST_WRITEBACK && wb_done_i) begin
         invalidate_o[sel_q] = 1'b1;
      end
      if (state_q == ddr2_cache_pkg::ST_FILL && fill_done_i) begin
         validate_o[sel_q] = 1'b1;
      end
      if (cache_write_i) begin
         set_dirty_o[sel_line_o] = 1'b1;
      end
   end

   a_one_hit: assert property (@(posedge wb_clk) disable iff (wb_rst) $onehot0(line_hit_i))
      else $error("address hits more than one cache line");

endmodule

`default_nettype wire

// ==== wb_slave_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_slave_port (
   input  wire                                            wb_clk,
   input  wire                                            wb_rst,
   input  wire                                            wb_cyc_i,
   input  wire                                            wb_stb_i,
   input  wire                                            wb_we_i,
   input  wire ddr2_cache_pkg::wb_addr_t                  wb_adr_i,
   input  wire [3:0]                                      wb_sel_i,
   input  wire ddr2_cache_pkg::wb_cti_e                   wb_cti_i,
   input  wire ddr2_cache_pkg::wb_bte_e                   wb_bte_i,
   input  wire                                            mem_init_done_i,
   input  wire                                            hit_i,
   input  wire                                            busy_i,
   output logic                                           req_o,
   output logic [ddr2_cache_pkg::WORDS_PER_LINE_LOG2-1:0] line_word_o,
   output logic [3:0]                                     word_sel_we_o,
   output logic                                           cache_write_o,
   output logic                                           wb_ack_o
);

   localparam int word_w = ddr2_cache_pkg::WORDS_PER_LINE_LOG2;

   logic req_q;
   logic req_new;
   logic req_hit;
   logic bursting_q;
   logic ack_q;
   logic burst_incr;
   logic [word_w-1:0] adr_word;
   logic [word_w-1:0] burst_word_q;

   // Next word of a burst, wrapping inside the BTE window
   function automatic logic [word_w-1:0] next_word(input logic [word_w-1:0] w,
                                                   input ddr2_cache_pkg::wb_bte_e bte);
      logic [word_w-1:0] inc;
      inc = w + 1'b1;
      case (bte)
         ddr2_cache_pkg::BTE_WRAP4: return {w[word_w-1:2], inc[1:0]};
         ddr2_cache_pkg::BTE_WRAP8: return {w[word_w-1:3], inc[2:0]};
         ddr2_cache_pkg::BTE_WRAP16: return {w[word_w-1:4], inc[3:0]};
         default: return inc;
      endcase
   endfunction

   assign req_o = wb_cyc_i && wb_stb_i && mem_init_done_i;
   assign req_new = req_o && !req_q;
   assign req_hit = req_o && hit_i && !busy_i;
   assign adr_word = wb_adr_i[word_w+1:2];
   // Reads step ahead on every hit, writes step on their ack
   assign burst_incr = req_hit && (!wb_we_i || wb_ack_o);
   assign line_word_o = bursting_q ? burst_word_q : adr_word;
   assign word_sel_we_o = (wb_we_i && wb_ack_o) ? wb_sel_i : 4'b0000;
   assign cache_write_o = req_o && wb_we_i && wb_ack_o;

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         req_q <= 1'b0;
         bursting_q <= 1'b0;
         ack_q <= 1'b0;
         wb_ack_o <= 1'b0;
      end else begin
         req_q <= req_o;
         ack_q <= wb_ack_o;
         // Classic acks are single with a gap, burst acks run until CTI_END
         wb_ack_o <= req_hit &&
                     ((!bursting_q && !wb_ack_o && !ack_q) ||
                      (bursting_q && wb_cti_i != ddr2_cache_pkg::CTI_END));
         if (wb_ack_o && wb_cti_i == ddr2_cache_pkg::CTI_END) begin
            bursting_q <= 1'b0;
         end else if (req_new) begin
            bursting_q <= (wb_cti_i == ddr2_cache_pkg::CTI_INCR);
         end
      end
   end

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         burst_word_q <= '0;
      end else if (req_new) begin
         // A read hit already has its first word in flight
         burst_word_q <= (req_hit && !wb_we_i) ? next_word(adr_word, wb_bte_i) : adr_word;
      end else if (burst_incr) begin
         burst_word_q <= next_word(burst_word_q, wb_bte_i);
      end
   end

endmodule

`default_nettype wire

// ==== line_xfer_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_xfer_engine #(
   parameter int words_per_line_log2 = ddr2_cache_pkg::WORDS_PER_LINE_LOG2
) (
   input  wire                            wb_clk,
   input  wire                            wb_rst,
   input  wire                            start_wb_i,
   input  wire                            start_fill_i,
   input  wire ddr2_cache_pkg::tag_t      victim_tag_i,
   input  wire ddr2_cache_pkg::tag_t      fill_tag_i,
   input  wire ddr2_cache_pkg::mem_data_t ram_rdata_i,
   output logic [words_per_line_log2-3:0] ram_beat_o,
   output logic                           ram_we_o,
   output logic                           mem_cmd_valid_o,
   output ddr2_cache_pkg::mem_cmd_e       mem_cmd_o,
   output ddr2_cache_pkg::wb_addr_t       mem_cmd_addr_o,
   input  wire                            mem_cmd_afull_i,
   output logic                           mem_wdata_valid_o,
   output ddr2_cache_pkg::mem_data_t      mem_wdata_o,
   input  wire                            mem_wdata_afull_i,
   input  wire                            mem_rdata_valid_i,
   output logic                           busy_o,
   output logic                           wb_done_o,
   output logic                           fill_done_o
);

   localparam int beat_w = words_per_line_log2 - 2;
   localparam int cmds_per_line = (1 << beat_w) / ddr2_cache_pkg::BEATS_PER_CMD;
   localparam int cmd_w = $clog2(cmds_per_line);
   localparam int cmd_off_w = $clog2(ddr2_cache_pkg::BEATS_PER_CMD) + 4;

   typedef enum logic [1:0] {X_IDLE, X_WB_DATA, X_WB_CMD, X_FILL} xfer_state_e;

   xfer_state_e state_q;
   logic [cmd_w:0] cmd_cnt_q;
   logic rd_en;
   logic cmd_en;
   logic last_beat;
   ddr2_cache_pkg::tag_t cmd_tag;

   assign last_beat = &ram_beat_o;
   assign rd_en = (state_q == X_WB_DATA) && !mem_wdata_afull_i;
   // Top bit of the command counter marks all commands issued
   assign cmd_en = (state_q == X_WB_CMD || state_q == X_FILL) && !mem_cmd_afull_i &&
                   !cmd_cnt_q[cmd_w];
   assign ram_we_o = (state_q == X_FILL) && mem_rdata_valid_i;
   assign busy_o = (state_q != X_IDLE);
   // RAM output is registered, so it lines up with the valid strobe
   assign mem_wdata_o = ram_rdata_i;
   assign cmd_tag = (state_q == X_FILL) ? fill_tag_i : victim_tag_i;

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         state_q <= X_IDLE;
         ram_beat_o <= '0;
         cmd_cnt_q <= '0;
         mem_cmd_valid_o <= 1'b0;
         mem_wdata_valid_o <= 1'b0;
         wb_done_o <= 1'b0;
         fill_done_o <= 1'b0;
      end else begin
         mem_cmd_valid_o <= cmd_en;
         mem_wdata_valid_o <= rd_en;
         wb_done_o <= 1'b0;
         fill_done_o <= 1'b0;
         if (cmd_en) begin
            cmd_cnt_q <= cmd_cnt_q + 1'b1;
         end
         if (rd_en || ram_we_o) begin
            ram_beat_o <= ram_beat_o + 1'b1;
         end
         case (state_q)
            X_IDLE: begin
               if (start_wb_i) begin
                  state_q <= X_WB_DATA;
               end else if (start_fill_i) begin
                  state_q <= X_FILL;
               end
            end
            X_WB_DATA: begin
               if (rd_en && last_beat) begin
                  state_q <= X_WB_CMD;
               end
            end
            X_WB_CMD: begin
               if (cmd_cnt_q[cmd_w]) begin
                  state_q <= X_IDLE;
                  cmd_cnt_q <= '0;
                  wb_done_o <= 1'b1;
               end
            end
            default: begin
               if (ram_we_o && last_beat) begin
                  state_q <= X_IDLE;
                  cmd_cnt_q <= '0;
                  fill_done_o <= 1'b1;
               end
            end
         endcase
      end
   end

   always_ff @(posedge wb_clk) begin
      if (cmd_en) begin
         mem_cmd_o <= (state_q == X_FILL) ? ddr2_cache_pkg::MEM_READ : ddr2_cache_pkg::MEM_WRITE;
         mem_cmd_addr_o <= {cmd_tag, cmd_cnt_q[cmd_w-1:0], {cmd_off_w{1'b0}}};
      end
   end

   a_no_idle_beat: assert property (@(posedge wb_clk) disable iff (wb_rst)
      (state_q == X_IDLE) |-> !mem_rdata_valid_i)
      else $error("memory read beat while no fill is running");

endmodule

`default_nettype wire

// ==== cache_data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_data_ram #(
   parameter int num_lines = ddr2_cache_pkg::NUM_LINES,
   parameter int words_per_line_log2 = ddr2_cache_pkg::WORDS_PER_LINE_LOG2
) (
   input  wire                                                 wb_clk,
   input  wire                                                 a_en_i,
   input  wire [3:0]                                           a_we_i,
   input  wire [$clog2(num_lines)+words_per_line_log2-1:0]     a_addr_i,
   input  wire ddr2_cache_pkg::wb_data_t                       a_wdata_i,
   output ddr2_cache_pkg::wb_data_t                            a_rdata_o,
   input  wire                                                 b_en_i,
   input  wire                                                 b_we_i,
   input  wire [$clog2(num_lines)+words_per_line_log2-3:0]     b_addr_i,
   input  wire ddr2_cache_pkg::mem_data_t                      b_wdata_i,
   output ddr2_cache_pkg::mem_data_t                           b_rdata_o
);

   localparam int a_w = $clog2(num_lines) + words_per_line_log2;

   // Four words per beat, lowest word in bits 31:0
   ddr2_cache_pkg::mem_data_t mem [1 << (a_w - 2)];

   always_ff @(posedge wb_clk) begin
      if (a_en_i) begin
         for (int i = 0; i < 4; i++) begin
            if (a_we_i[i]) begin
               mem[a_addr_i[a_w-1:2]][a_addr_i[1:0]*32 + i*8 +: 8] <= a_wdata_i[i*8 +: 8];
            end
         end
         a_rdata_o <= mem[a_addr_i[a_w-1:2]][a_addr_i[1:0]*32 +: 32];
      end
      if (b_en_i) begin
         if (b_we_i) begin
            mem[b_addr_i] <= b_wdata_i;
         end
         b_rdata_o <= mem[b_addr_i];
      end
   end

endmodule

`default_nettype wire

// ==== ddr2_wb_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddr2_wb_cache #(
   parameter int num_lines = ddr2_cache_pkg::NUM_LINES,
   parameter int words_per_line_log2 = ddr2_cache_pkg::WORDS_PER_LINE_LOG2
) (
   input  wire                            wb_clk,
   input  wire                            wb_rst,
   input  wire                            wb_cyc_i,
   input  wire                            wb_stb_i,
   input  wire                            wb_we_i,
   input  wire ddr2_cache_pkg::wb_addr_t  wb_adr_i,
   input  wire ddr2_cache_pkg::wb_data_t  wb_dat_i,
   input  wire [3:0]                      wb_sel_i,
   input  wire ddr2_cache_pkg::wb_cti_e   wb_cti_i,
   input  wire ddr2_cache_pkg::wb_bte_e   wb_bte_i,
   output ddr2_cache_pkg::wb_data_t       wb_dat_o,
   output logic                           wb_ack_o,
   input  wire                            mem_init_done_i,
   output logic                           mem_cmd_valid_o,
   output ddr2_cache_pkg::mem_cmd_e       mem_cmd_o,
   output ddr2_cache_pkg::wb_addr_t       mem_cmd_addr_o,
   input  wire                            mem_cmd_afull_i,
   output logic                           mem_wdata_valid_o,
   output ddr2_cache_pkg::mem_data_t      mem_wdata_o,
   input  wire                            mem_wdata_afull_i,
   input  wire                            mem_rdata_valid_i,
   input  wire ddr2_cache_pkg::mem_data_t mem_rdata_i
);

   localparam int line_w = $clog2(num_lines);
   localparam int off_w = words_per_line_log2 + 2;

   wire [num_lines-1:0] line_hit;
   wire [num_lines-1:0] line_valid;
   wire [num_lines-1:0] line_dirty;
   wire [num_lines-1:0] validate;
   wire [num_lines-1:0] invalidate;
   wire [num_lines-1:0] set_dirty;
   wire ddr2_cache_pkg::tag_t line_tag [num_lines];
   wire ddr2_cache_pkg::tag_t victim_tag;
   wire ddr2_cache_pkg::mem_data_t ram_rdata;
   wire [line_w-1:0] sel_line;
   wire [words_per_line_log2-1:0] line_word;
   wire [words_per_line_log2-3:0] ram_beat;
   wire [3:0] word_sel_we;
   wire req;
   wire cache_write;
   wire start_wb;
   wire start_fill;
   wire wb_done;
   wire fill_done;
   wire ram_we;
   wire busy;

   for (genvar i = 0; i < num_lines; i++) begin : g_line
      cache_tag_reg u_tag (
         .wb_clk(wb_clk), .wb_rst(wb_rst), .tag_i(wb_adr_i[31:off_w]),
         .validate_i(validate[i]), .invalidate_i(invalidate[i]),
         .set_dirty_i(set_dirty[i]), .hit_o(line_hit[i]), .valid_o(line_valid[i]),
         .dirty_o(line_dirty[i]), .tag_o(line_tag[i]));
   end

   cache_line_ctrl #(.num_lines(num_lines)) u_ctrl (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .req_i(req), .cache_write_i(cache_write),
      .line_hit_i(line_hit), .line_valid_i(line_valid), .line_dirty_i(line_dirty),
      .line_tag_i(line_tag), .wb_done_i(wb_done), .fill_done_i(fill_done),
      .validate_o(validate), .invalidate_o(invalidate), .set_dirty_o(set_dirty),
      .sel_line_o(sel_line), .victim_tag_o(victim_tag), .start_wb_o(start_wb),
      .start_fill_o(start_fill));

   wb_slave_port u_wb (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
      .wb_we_i(wb_we_i), .wb_adr_i(wb_adr_i), .wb_sel_i(wb_sel_i), .wb_cti_i(wb_cti_i),
      .wb_bte_i(wb_bte_i), .mem_init_done_i(mem_init_done_i), .hit_i(|line_hit),
      .busy_i(busy), .req_o(req), .line_word_o(line_word), .word_sel_we_o(word_sel_we),
      .cache_write_o(cache_write), .wb_ack_o(wb_ack_o));

   line_xfer_engine #(.words_per_line_log2(words_per_line_log2)) u_xfer (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .start_wb_i(start_wb), .start_fill_i(start_fill),
      .victim_tag_i(victim_tag), .fill_tag_i(wb_adr_i[31:off_w]), .ram_rdata_i(ram_rdata),
      .ram_beat_o(ram_beat), .ram_we_o(ram_we), .mem_cmd_valid_o(mem_cmd_valid_o),
      .mem_cmd_o(mem_cmd_o), .mem_cmd_addr_o(mem_cmd_addr_o),
      .mem_cmd_afull_i(mem_cmd_afull_i), .mem_wdata_valid_o(mem_wdata_valid_o),
      .mem_wdata_o(mem_wdata_o), .mem_wdata_afull_i(mem_wdata_afull_i),
      .mem_rdata_valid_i(mem_rdata_valid_i), .busy_o(busy), .wb_done_o(wb_done),
      .fill_done_o(fill_done));

   // Wishbone side is shut off while a line moves
   cache_data_ram #(.num_lines(num_lines), .words_per_line_log2(words_per_line_log2)) u_ram (
      .wb_clk(wb_clk), .a_en_i(!busy), .a_we_i(word_sel_we), .a_addr_i({sel_line, line_word}),
      .a_wdata_i(wb_dat_i), .a_rdata_o(wb_dat_o), .b_en_i(busy), .b_we_i(ram_we),
      .b_addr_i({sel_line, ram_beat}), .b_wdata_i(mem_rdata_i), .b_rdata_o(ram_rdata));

endmodule

`default_nettype wire

// ==== mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_model (
   input  wire                            wb_clk,
   input  wire                            wb_rst,
   input  wire                            cmd_valid_i,
   input  wire ddr2_cache_pkg::mem_cmd_e  cmd_i,
   input  wire ddr2_cache_pkg::wb_addr_t  cmd_addr_i,
   output logic                           cmd_afull_o,
   input  wire                            wdata_valid_i,
   input  wire ddr2_cache_pkg::mem_data_t wdata_i,
   output logic                           wdata_afull_o,
   output logic                           rdata_valid_o,
   output ddr2_cache_pkg::mem_data_t      rdata_o
);

   // Words keyed by their aligned byte address
   ddr2_cache_pkg::wb_data_t mem_q [ddr2_cache_pkg::wb_addr_t];
   ddr2_cache_pkg::mem_data_t wbeat_q [$];
   ddr2_cache_pkg::wb_addr_t rbeat_q [$];

   // Unwritten words follow their own address
   function automatic ddr2_cache_pkg::wb_data_t read_word(input ddr2_cache_pkg::wb_addr_t a);
      if (mem_q.exists(a)) begin
         return mem_q[a];
      end
      return a ^ 32'h5a5a0000;
   endfunction

   always @(posedge wb_clk) begin : model_step
      ddr2_cache_pkg::mem_data_t beat;
      ddr2_cache_pkg::wb_addr_t a;
      if (wb_rst) begin
         cmd_afull_o <= 1'b0;
         wdata_afull_o <= 1'b0;
         rdata_valid_o <= 1'b0;
         rdata_o <= '0;
         wbeat_q.delete();
         rbeat_q.delete();
      end else begin
         cmd_afull_o <= ($urandom % 4) == 0;
         wdata_afull_o <= ($urandom % 4) == 0;
         if (wdata_valid_i) begin
            wbeat_q.push_back(wdata_i);
         end
         if (cmd_valid_i && cmd_i == ddr2_cache_pkg::MEM_READ) begin
            rbeat_q.push_back(cmd_addr_i);
            rbeat_q.push_back(cmd_addr_i + 32'd16);
         end else if (cmd_valid_i) begin
            // Write data beats arrive ahead of their command
            for (int b = 0; b < 2; b++) begin
               beat = (wbeat_q.size() != 0) ? wbeat_q.pop_front() : '0;
               for (int w = 0; w < 4; w++) begin
                  mem_q[cmd_addr_i + 32'(b * 16 + w * 4)] = beat[w*32 +: 32];
               end
            end
         end
         rdata_valid_o <= 1'b0;
         if (rbeat_q.size() != 0 && ($urandom % 3) != 0) begin
            a = rbeat_q.pop_front();
            for (int w = 0; w < 4; w++) begin
               beat[w*32 +: 32] = read_word(a + 32'(w * 4));
            end
            rdata_valid_o <= 1'b1;
            rdata_o <= beat;
         end
      end
   end

endmodule

`default_nettype wire

// ==== tb_ddr2_wb_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ddr2_wb_cache;

   localparam int num_tests = 5;

   logic wb_clk;
   logic wb_rst;
   logic wb_cyc;
   logic wb_stb;
   logic wb_we;
   ddr2_cache_pkg::wb_addr_t wb_adr;
   ddr2_cache_pkg::wb_data_t wb_dat_w;
   ddr2_cache_pkg::wb_data_t wb_dat_r;
   logic [3:0] wb_sel;
   ddr2_cache_pkg::wb_cti_e wb_cti;
   ddr2_cache_pkg::wb_bte_e wb_bte;
   logic wb_ack;
   logic mem_init_done;
   logic mem_cmd_valid;
   ddr2_cache_pkg::mem_cmd_e mem_cmd;
   ddr2_cache_pkg::wb_addr_t mem_cmd_addr;
   logic mem_cmd_afull;
   logic mem_wdata_valid;
   ddr2_cache_pkg::mem_data_t mem_wdata;
   logic mem_wdata_afull;
   logic mem_rdata_valid;
   ddr2_cache_pkg::mem_data_t mem_rdata;

   // Every word written so far, as the memory should see it
   ddr2_cache_pkg::wb_data_t exp_mem [ddr2_cache_pkg::wb_addr_t];
   ddr2_cache_pkg::wb_data_t exp_dat;
   int err_cnt = 0;
   int err_mark = 0;
   int fail_cnt = 0;
   int test_no = 0;

   ddr2_wb_cache u_dut (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb),
      .wb_we_i(wb_we), .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w), .wb_sel_i(wb_sel),
      .wb_cti_i(wb_cti), .wb_bte_i(wb_bte), .wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack),
      .mem_init_done_i(mem_init_done), .mem_cmd_valid_o(mem_cmd_valid), .mem_cmd_o(mem_cmd),
      .mem_cmd_addr_o(mem_cmd_addr), .mem_cmd_afull_i(mem_cmd_afull),
      .mem_wdata_valid_o(mem_wdata_valid), .mem_wdata_o(mem_wdata),
      .mem_wdata_afull_i(mem_wdata_afull), .mem_rdata_valid_i(mem_rdata_valid),
      .mem_rdata_i(mem_rdata));

   mem_model u_mem (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .cmd_valid_i(mem_cmd_valid), .cmd_i(mem_cmd),
      .cmd_addr_i(mem_cmd_addr), .cmd_afull_o(mem_cmd_afull), .wdata_valid_i(mem_wdata_valid),
      .wdata_i(mem_wdata), .wdata_afull_o(mem_wdata_afull), .rdata_valid_o(mem_rdata_valid),
      .rdata_o(mem_rdata));

   initial begin
      wb_clk = 1'b0;
      forever #2 wb_clk = ~wb_clk;
   end

   a_reset_quiet: assert property (@(posedge wb_clk)
      wb_rst |=> !wb_ack && !mem_cmd_valid && !mem_wdata_valid)
      else begin
         err_cnt++;
         $display("ack or a memory strobe is high right after reset");
      end
   a_no_early_ack: assert property (@(posedge wb_clk) disable iff (wb_rst)
      !mem_init_done |=> !wb_ack)
      else begin
         err_cnt++;
         $display("ack came before memory init was done");
      end
   a_classic_ack: assert property (@(posedge wb_clk) disable iff (wb_rst)
      wb_ack && wb_cti == ddr2_cache_pkg::CTI_CLASSIC |=> !wb_ack [*2])
      else begin
         err_cnt++;
         $display("classic ack lasted more than one cycle or came back too soon");
      end
   a_burst_ack: assert property (@(posedge wb_clk) disable iff (wb_rst)
      wb_ack && wb_cti == ddr2_cache_pkg::CTI_INCR |=> wb_ack)
      else begin
         err_cnt++;
         $display("burst ack dropped before the end beat");
      end
   a_burst_end: assert property (@(posedge wb_clk) disable iff (wb_rst)
      wb_ack && wb_cti == ddr2_cache_pkg::CTI_END |=> !wb_ack)
      else begin
         err_cnt++;
         $display("ack stayed high after the burst end beat");
      end
   a_read_data: assert property (@(posedge wb_clk) disable iff (wb_rst)
      wb_ack && !wb_we |-> wb_dat_r == exp_dat)
      else begin
         err_cnt++;
         $display("mismatch wb_dat_o: got %h, expected %h", $sampled(wb_dat_r), $sampled(exp_dat));
      end

   // Line n sits well apart from its neighbours, word offset within it
   function automatic ddr2_cache_pkg::wb_addr_t line_addr(input int line, input int word);
      return 32'h0040_0000 + 32'(line) * 32'h0000_1080 + 32'(word) * 32'd4;
   endfunction

   function automatic ddr2_cache_pkg::wb_data_t expect_word(input ddr2_cache_pkg::wb_addr_t a);
      ddr2_cache_pkg::wb_addr_t w;
      w = {a[31:2], 2'b00};
      if (exp_mem.exists(w)) begin
         return exp_mem[w];
      end
      return w ^ 32'h5a5a0000;
   endfunction

   function automatic ddr2_cache_pkg::wb_data_t merge_bytes(input ddr2_cache_pkg::wb_data_t old,
                                                            input ddr2_cache_pkg::wb_data_t d,
                                                            input logic [3:0] sel);
      ddr2_cache_pkg::wb_data_t r;
      r = old;
      for (int i = 0; i < 4; i++) begin
         if (sel[i]) begin
            r[i*8 +: 8] = d[i*8 +: 8];
         end
      end
      return r;
   endfunction

   // Next beat address, wrapping inside the 4, 8 or 16 word window
   function automatic ddr2_cache_pkg::wb_addr_t wrap_next(input ddr2_cache_pkg::wb_addr_t a,
                                                          input ddr2_cache_pkg::wb_bte_e bte);
      ddr2_cache_pkg::wb_addr_t nxt;
      nxt = a + 32'd4;
      case (bte)
         ddr2_cache_pkg::BTE_WRAP4: nxt = {a[31:4], nxt[3:0]};
         ddr2_cache_pkg::BTE_WRAP8: nxt = {a[31:5], nxt[4:0]};
         ddr2_cache_pkg::BTE_WRAP16: nxt = {a[31:6], nxt[5:0]};
         default: nxt = a + 32'd4;
      endcase
      return nxt;
   endfunction

   task automatic wait_ack();
      do begin
         @(posedge wb_clk);
      end while (!wb_ack);
   endtask

   task automatic read_classic(input ddr2_cache_pkg::wb_addr_t a);
      @(posedge wb_clk);
      exp_dat <= expect_word(a);
      wb_cyc <= 1'b1;
      wb_stb <= 1'b1;
      wb_we <= 1'b0;
      wb_adr <= a;
      wb_cti <= ddr2_cache_pkg::CTI_CLASSIC;
      wb_bte <= ddr2_cache_pkg::BTE_LINEAR;
      wait_ack();
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
   endtask

   task automatic write_classic(input ddr2_cache_pkg::wb_addr_t a,
                                input ddr2_cache_pkg::wb_data_t d, input logic [3:0] sel);
      @(posedge wb_clk);
      wb_cyc <= 1'b1;
      wb_stb <= 1'b1;
      wb_we <= 1'b1;
      wb_adr <= a;
      wb_dat_w <= d;
      wb_sel <= sel;
      wb_cti <= ddr2_cache_pkg::CTI_CLASSIC;
      wb_bte <= ddr2_cache_pkg::BTE_LINEAR;
      wait_ack();
      exp_mem[{a[31:2], 2'b00}] = merge_bytes(expect_word(a), d, sel);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we <= 1'b0;
   endtask

   task automatic burst_read(input ddr2_cache_pkg::wb_addr_t start,
                             input ddr2_cache_pkg::wb_bte_e bte, input int beats);
      ddr2_cache_pkg::wb_addr_t a;
      a = start;
      @(posedge wb_clk);
      exp_dat <= expect_word(a);
      wb_cyc <= 1'b1;
      wb_stb <= 1'b1;
      wb_we <= 1'b0;
      wb_adr <= a;
      wb_cti <= ddr2_cache_pkg::CTI_INCR;
      wb_bte <= bte;
      for (int n = 1; n < beats; n++) begin
         wait_ack();
         a = wrap_next(a, bte);
         exp_dat <= expect_word(a);
         wb_adr <= a;
         if (n == beats - 1) begin
            wb_cti <= ddr2_cache_pkg::CTI_END;
         end
      end
      wait_ack();
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_cti <= ddr2_cache_pkg::CTI_CLASSIC;
   endtask

   task automatic check_model_word(input ddr2_cache_pkg::wb_addr_t a);
      assert (u_mem.mem_q.exists(a))
         else begin
            err_cnt++;
            $display("written word at %h never reached the memory model", a);
         end
      if (u_mem.mem_q.exists(a)) begin
         assert (u_mem.mem_q[a] == expect_word(a))
            else begin
               err_cnt++;
               $display("mismatch model word %h: got %h, expected %h", a, u_mem.mem_q[a],
                        expect_word(a));
            end
      end
   endtask

   task automatic report_test(input string name);
      // Trailing ack checks span a few cycles
      repeat (4) @(posedge wb_clk);
      test_no++;
      if (err_cnt == err_mark) begin
         $display("test %0d %s: ok", test_no, name);
      end else begin
         fail_cnt++;
         $display("test %0d %s: %0d errors", test_no, name, err_cnt - err_mark);
      end
      err_mark = err_cnt;
   endtask

   initial begin
      repeat (num_tests * 16 * 200) @(posedge wb_clk);
      $display("timeout after %0d cycles, the run did not finish", num_tests * 16 * 200);
      $display("** FAIL **");
      $finish;
   end

   initial begin : stimulus
      ddr2_cache_pkg::wb_addr_t a;
      void'($urandom(32'hdcd4));
      wb_rst = 1'b1;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
      wb_adr = '0;
      wb_dat_w = '0;
      wb_sel = 4'h0;
      wb_cti = ddr2_cache_pkg::CTI_CLASSIC;
      wb_bte = ddr2_cache_pkg::BTE_LINEAR;
      mem_init_done = 1'b0;
      exp_dat = '0;
      repeat (10) @(posedge wb_clk);
      wb_rst <= 1'b0;

      // Request is held while the memory still initialises
      fork
         read_classic(line_addr(1, 0));
         begin
            repeat (100) @(posedge wb_clk);
            mem_init_done <= 1'b1;
         end
      join
      report_test("ack held off until init done");

      read_classic(line_addr(2, 3));
      read_classic(line_addr(2, 3));
      read_classic(line_addr(2, 17));
      report_test("classic read of unwritten words");

      for (int i = 0; i < 4; i++) begin
         a = line_addr(3, $urandom % 32);
         write_classic(a, $urandom, 4'($urandom));
         read_classic(a);
      end
      report_test("byte select write and read back");

      // First pass misses, second pass hits
      for (int k = 0; k < 2; k++) begin
         burst_read(line_addr(4, 4), ddr2_cache_pkg::BTE_LINEAR, 8);
         burst_read(line_addr(5, 6), ddr2_cache_pkg::BTE_WRAP4, 4);
         burst_read(line_addr(6, 13), ddr2_cache_pkg::BTE_WRAP8, 8);
         burst_read(line_addr(7, 21), ddr2_cache_pkg::BTE_WRAP16, 16);
      end
      report_test("incrementing bursts with each wrap");

      a = line_addr(8, 9);
      write_classic(a, $urandom, 4'($urandom));
      for (int n = 9; n <= 12; n++) begin
         read_classic(line_addr(n, 0));
      end
      check_model_word(a);
      read_classic(a);
      report_test("dirty line evicted and refilled");

      $display("tests %0d, failed %0d, errors %0d", test_no, fail_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
ddr2_cache_pkg.sv
cache_tag_reg.sv
cache_line_ctrl.sv
wb_slave_port.sv
line_xfer_engine.sv
cache_data_ram.sv
ddr2_wb_cache.sv
mem_model.sv
tb_ddr2_wb_cache.sv

// ==== Bender.yml ====
package:
  name: ddr2_wb_cache

sources:
  - ddr2_cache_pkg.sv
  - cache_tag_reg.sv
  - cache_line_ctrl.sv
  - wb_slave_port.sv
  - line_xfer_engine.sv
  - cache_data_ram.sv
  - ddr2_wb_cache.sv
  - target: test
    files:
      - mem_model.sv
      - tb_ddr2_wb_cache.sv
